// ==== common/spi_cmd_pkg.sv ====
package spi_cmd_pkg;

  typedef logic [7:0] byte_t;

  // host opcodes still decoded
  localparam byte_t cmd_get_cookie       = 8'd0;
  localparam byte_t cmd_data_ready       = 8'd5;
  localparam byte_t cmd_get_version      = 8'd15;
  localparam byte_t cmd_set_screen_color = 8'd17;
  localparam byte_t cmd_abus_read        = 8'd18;
  localparam byte_t cmd_set_led          = 8'd26;

  // fixed reply values
  localparam byte_t      cookie        = 8'haf;
  localparam logic [2:0] version_major = 3'd0;
  localparam logic [4:0] version_minor = 5'd3; // packed with major gives 03h

  // parameter store, sized for set_screen_color
  localparam int max_params = 3;
  typedef logic [1:0] param_idx_t;
  typedef byte_t [max_params-1:0] params_t; // params[0] is the first byte received

  // one pre-shift edge plus eight data bits
  localparam int reply_bits = 9;

endpackage

// ==== common/trs_bus_pkg.sv ====
package trs_bus_pkg;

  typedef logic [7:0] port_t;

  localparam port_t      trs_io_port   = 8'h1f;
  localparam logic [3:0] frehd_port_hi = 4'hc; // FreHD owns c0h..cfh

  // status code shown to the host on esp_s
  typedef logic [3:0] esp_s_t;
  localparam esp_s_t esp_trs_io_in  = 4'd0;
  localparam esp_s_t esp_trs_io_out = 4'd1;
  localparam esp_s_t esp_frehd_in   = 4'd2;
  localparam esp_s_t esp_frehd_out  = 4'd3;
  localparam esp_s_t esp_idle       = 4'hf;

  // request pulse length in clk cycles, fits the 6-bit counter
  localparam int req_pulse_cycles = 50;

  // flops per asynchronous input
  localparam int sync_stages = 2;

endpackage

// ==== spi/spi_link.sv ====
module spi_link
  import spi_cmd_pkg::*, trs_bus_pkg::*;
(
  input  logic  clk,
  input  logic  cass_out_sel_n,
  input  logic  sck,
  input  logic  cs_n,
  input  logic  mosi,
  input  logic  reply_load,
  input  byte_t tx_byte,
  input  logic  accept,
  output logic  rx_valid,
  output byte_t rx_byte,
  output logic  msg_idle,
  output logic  tx_busy,
  output logic  miso
);

  logic [sync_stages-1:0] sck_sync;
  logic [sync_stages-1:0] cs_sync;
  logic [sync_stages-1:0] mosi_sync;
  logic                   sck_d;      // edge detect register
  logic                   sck_rise;
  logic                   sck_fall;
  logic [2:0]             bit_cnt;
  logic [3:0]             tx_cnt;     // reply bits still owed
  byte_t                  tx_shift;

  always_ff @(posedge clk or negedge cass_out_sel_n) begin
    if (!cass_out_sel_n) begin
      sck_sync  <= '0;
      cs_sync   <= '1; // deselected
      mosi_sync <= '0;
      sck_d     <= 1'b0;
    end else begin
      sck_sync  <= {sck_sync[sync_stages-2:0], sck};
      cs_sync   <= {cs_sync[sync_stages-2:0], cs_n};
      mosi_sync <= {mosi_sync[sync_stages-2:0], mosi};
      sck_d     <= sck_sync[sync_stages-1];
    end
  end

  assign sck_rise = sck_sync[sync_stages-1] & ~sck_d;
  assign sck_fall = ~sck_sync[sync_stages-1] & sck_d;
  assign msg_idle = cs_sync[sync_stages-1];

  // receive side, bit count restarts with every select
  always_ff @(posedge clk or negedge cass_out_sel_n) begin
    if (!cass_out_sel_n) begin
      bit_cnt  <= '0;
      rx_valid <= 1'b0;
    end else begin
      rx_valid <= sck_rise && !msg_idle && (bit_cnt == 3'd7) && accept; // 8th bit
      if (msg_idle)
        bit_cnt <= '0;
      else if (sck_rise)
        bit_cnt <= bit_cnt + 3'd1;
    end
  end

  always_ff @(posedge clk) begin
    if (sck_rise && !msg_idle)
      rx_byte <= {rx_byte[6:0], mosi_sync[sync_stages-1]}; // msb first
  end

  // transmit side, reply goes out in the byte after the command
  always_ff @(posedge clk or negedge cass_out_sel_n) begin
    if (!cass_out_sel_n) begin
      tx_cnt   <= '0;
      tx_shift <= '0;
    end else if (msg_idle) begin
      tx_cnt   <= '0;
      tx_shift <= '0; // miso parks low between messages
    end else if (reply_load) begin
      tx_cnt <= 4'(reply_bits);
    end else if (sck_fall && (tx_cnt != '0)) begin
      tx_cnt <= tx_cnt - 4'd1;
      if (tx_cnt == 4'(reply_bits))
        tx_shift <= tx_byte;              // count steps to eight, msb now on miso
      else
        tx_shift <= {tx_shift[6:0], 1'b0};
    end
  end

  assign tx_busy = (tx_cnt != '0);
  assign miso    = tx_shift[7];

  // a reply is armed a cycle after its command byte, never alongside a new byte
  a_no_rx_on_load: assert property (@(posedge clk) disable iff (!cass_out_sel_n)
    !(rx_valid && reply_load));

endmodule

// ==== rtl/cmd_ctrl.sv ====
module cmd_ctrl
  import spi_cmd_pkg::*;
(
  input  logic    clk,
  input  logic    cass_out_sel_n,
  input  logic    rx_valid,
  input  byte_t   rx_byte,
  input  logic    msg_idle,
  input  logic    tx_busy,
  output logic    action,
  output logic    reply_load,
  output logic    data_ready_set,
  output logic    bad_cmd,
  output logic    accept,
  output byte_t   cmd,
  output params_t params
);

  typedef enum logic {
    idle,
    read_bytes
  } state_t;

  state_t     state;
  param_idx_t idx;        // next parameter slot
  param_idx_t param_cnt;  // parameters owed by the current opcode
  param_idx_t op_params;
  logic       op_reply;
  logic       op_known;

  // opcode table
  always_comb begin
    op_params = '0;
    op_reply  = 1'b0;
    op_known  = 1'b1;
    case (rx_byte)
      cmd_get_cookie,
      cmd_get_version,
      cmd_abus_read:        op_reply = 1'b1;
      cmd_data_ready:       op_reply = 1'b0;  // no reply, just the irq
      cmd_set_led:          op_params = 2'd1;
      cmd_set_screen_color: op_params = param_idx_t'(max_params);
      default:              op_known = 1'b0;
    endcase
  end

  // bytes are taken unless a reply is still shifting out
  assign accept = (state == read_bytes) || !tx_busy;

  always_ff @(posedge clk or negedge cass_out_sel_n) begin
    if (!cass_out_sel_n) begin
      state          <= idle;
      idx            <= '0;
      param_cnt      <= '0;
      action         <= 1'b0;
      reply_load     <= 1'b0;
      data_ready_set <= 1'b0;
      bad_cmd        <= 1'b0;
    end else begin
      action         <= 1'b0;
      reply_load     <= 1'b0;
      data_ready_set <= 1'b0;
      bad_cmd        <= 1'b0;
      if (msg_idle) begin
        state <= idle;  // cs high aborts a half read command
        idx   <= '0;
      end else if (rx_valid) begin
        case (state)
          idle: begin
            idx       <= '0;
            param_cnt <= op_params;
            if (!op_known) begin
              bad_cmd <= 1'b1;
            end else if (op_params == '0) begin
              action         <= 1'b1;
              reply_load     <= op_reply;
              data_ready_set <= (rx_byte == cmd_data_ready);
            end else begin
              state <= read_bytes;
            end
          end
          read_bytes: begin
            if (idx == param_cnt - 2'd1) begin
              action <= 1'b1; // last parameter in
              state  <= idle;
            end else begin
              idx <= idx + 2'd1;
            end
          end
          default: state <= idle;
        endcase
      end
    end
  end

  // opcode and parameter bytes
  always_ff @(posedge clk) begin
    if (rx_valid && !msg_idle) begin
      if (state == idle)
        cmd <= rx_byte;
      else
        params[idx] <= rx_byte;
    end
  end

  a_idx_in_range: assert property (@(posedge clk) disable iff (!cass_out_sel_n)
    (state == read_bytes) |-> (idx < param_cnt));

endmodule

// ==== rtl/host_regs.sv ====
module host_regs
  import spi_cmd_pkg::*, trs_bus_pkg::*;
(
  input  logic        clk,
  input  logic        cass_out_sel_n,
  input  logic        action,
  input  logic        bad_cmd,
  input  byte_t       cmd,
  input  params_t     params,
  input  port_t       a,
  output byte_t       tx_byte,
  output logic        led_red,
  output logic        led_green,
  output logic        led_blue,
  output logic        err_led,
  output logic [23:0] screen_color
);

  always_ff @(posedge clk or negedge cass_out_sel_n) begin
    if (!cass_out_sel_n) begin
      led_red      <= 1'b0;
      led_green    <= 1'b0;
      led_blue     <= 1'b0;
      err_led      <= 1'b0;
      screen_color <= 24'hffffff; // white
    end else begin
      if (bad_cmd)
        err_led <= 1'b1;          // sticky until reset
      if (action) begin
        case (cmd)
          cmd_set_led: begin
            led_red   <= params[0][0];
            led_green <= params[0][1];
            led_blue  <= params[0][2];
          end
          cmd_set_screen_color:
            screen_color <= {params[0], params[1], params[2]}; // r g b
          default: ;
        endcase
      end
    end
  end

  // reply byte, held until the next reply command
  always_ff @(posedge clk) begin
    if (action) begin
      case (cmd)
        cmd_get_cookie:  tx_byte <= cookie;
        cmd_get_version: tx_byte <= {version_major, version_minor};
        cmd_abus_read:   tx_byte <= a;  // low address byte as seen now
        default: ;
      endcase
    end
  end

endmodule

// ==== rtl/esp_bridge.sv ====
module esp_bridge
  import trs_bus_pkg::*;
(
  input  logic   clk,
  input  logic   cass_out_sel_n,
  input  logic   ioreq_n,
  input  logic   in_n,
  input  logic   out_n,
  input  logic   done,
  input  logic   data_ready_set,
  input  port_t  a,
  output logic   req,
  output logic   wait_n,
  output logic   int_req,
  output esp_s_t esp_s
);

  logic [sync_stages-1:0] ioreq_sync;
  logic [sync_stages-1:0] in_sync;
  logic [sync_stages-1:0] out_sync;
  logic [sync_stages-1:0] done_sync;
  logic                   sel_d;
  logic                   done_d;
  logic                   rd_act, wr_act;
  logic                   trs_hit, frehd_hit;
  logic                   sel, sel_rise, done_rise;
  logic [5:0]             cnt;      // request pulse countdown

  always_ff @(posedge clk or negedge cass_out_sel_n) begin
    if (!cass_out_sel_n) begin
      ioreq_sync <= '1;
      in_sync    <= '1;
      out_sync   <= '1;
      done_sync  <= '0;
      sel_d      <= 1'b0;
      done_d     <= 1'b0;
    end else begin
      ioreq_sync <= {ioreq_sync[sync_stages-2:0], ioreq_n};
      in_sync    <= {in_sync[sync_stages-2:0], in_n};
      out_sync   <= {out_sync[sync_stages-2:0], out_n};
      done_sync  <= {done_sync[sync_stages-2:0], done};
      sel_d      <= sel;
      done_d     <= done_sync[sync_stages-1];
    end
  end

  // io cycle decode
  assign rd_act    = ~ioreq_sync[sync_stages-1] & ~in_sync[sync_stages-1];
  assign wr_act    = ~ioreq_sync[sync_stages-1] & ~out_sync[sync_stages-1];
  assign trs_hit   = (a == trs_io_port);
  assign frehd_hit = (a[7:4] == frehd_port_hi);
  assign sel       = (rd_act | wr_act) & (trs_hit | frehd_hit);
  assign sel_rise  = sel & ~sel_d;
  assign done_rise = done_sync[sync_stages-1] & ~done_d;

  always_comb begin
    esp_s = esp_idle;
    if (rd_act && trs_hit)
      esp_s = esp_trs_io_in;
    else if (wr_act && trs_hit)
      esp_s = esp_trs_io_out;
    else if (rd_act && frehd_hit)
      esp_s = esp_frehd_in;
    else if (wr_act && frehd_hit)
      esp_s = esp_frehd_out;
  end

  always_ff @(posedge clk or negedge cass_out_sel_n) begin
    if (!cass_out_sel_n) begin
      req     <= 1'b0;
      wait_n  <= 1'b1;
      cnt     <= '0;
      int_req <= 1'b0;
    end else begin
      if (sel_rise) begin
        req    <= 1'b1;  // a new access restarts the pulse
        wait_n <= 1'b0;
        cnt    <= 6'(req_pulse_cycles);
      end else begin
        if (done_rise)
          wait_n <= 1'b1; // host finished, let the z80 go
        if (cnt == 6'd1)
          req <= 1'b0;
        if (cnt != '0)
          cnt <= cnt - 6'd1;
      end
      if (data_ready_set)
        int_req <= 1'b1;
      else if (sel_rise && trs_hit)
        int_req <= 1'b0; // trs-io access acks the irq
    end
  end

  // an unbroken pulse ends after exactly req_pulse_cycles
  a_req_len: assert property (@(posedge clk) disable iff (!cass_out_sel_n)
    sel_rise ##1 (!sel_rise) [*req_pulse_cycles] |=> !req);

endmodule

// ==== rtl/trs_io_top.sv ====
module trs_io_top
  import spi_cmd_pkg::*, trs_bus_pkg::*;
(
  input  logic        clk,
  input  logic        cass_out_sel_n,
  input  logic        sck,
  input  logic        cs_n,
  input  logic        mosi,
  output logic        miso,
  input  logic        ioreq_n,
  input  logic        in_n,
  input  logic        out_n,
  input  port_t       a,
  input  logic        done,
  output logic        req,
  output esp_s_t      esp_s,
  output logic        wait_n,
  output logic        int_req,
  output logic        led_red,
  output logic        led_green,
  output logic        led_blue,
  output logic        err_led,
  output logic [23:0] screen_color
);

  logic    rx_valid;
  byte_t   rx_byte;
  logic    msg_idle;
  logic    tx_busy;
  logic    accept;
  logic    reply_load;
  byte_t   tx_byte;
  logic    action;
  logic    bad_cmd;
  logic    data_ready_set;
  byte_t   cmd;
  params_t params;

  spi_link u_spi_link (
    .clk            (clk),
    .cass_out_sel_n (cass_out_sel_n),
    .sck            (sck),
    .cs_n           (cs_n),
    .mosi           (mosi),
    .reply_load     (reply_load),
    .tx_byte        (tx_byte),
    .accept         (accept),
    .rx_valid       (rx_valid),
    .rx_byte        (rx_byte),
    .msg_idle       (msg_idle),
    .tx_busy        (tx_busy),
    .miso           (miso)
  );

  cmd_ctrl u_cmd_ctrl (
    .clk            (clk),
    .cass_out_sel_n (cass_out_sel_n),
    .rx_valid       (rx_valid),
    .rx_byte        (rx_byte),
    .msg_idle       (msg_idle),
    .tx_busy        (tx_busy),
    .action         (action),
    .reply_load     (reply_load),
    .data_ready_set (data_ready_set),
    .bad_cmd        (bad_cmd),
    .accept         (accept),
    .cmd            (cmd),
    .params         (params)
  );

  host_regs u_host_regs (
    .clk            (clk),
    .cass_out_sel_n (cass_out_sel_n),
    .action         (action),
    .bad_cmd        (bad_cmd),
    .cmd            (cmd),
    .params         (params),
    .a              (a),
    .tx_byte        (tx_byte),
    .led_red        (led_red),
    .led_green      (led_green),
    .led_blue       (led_blue),
    .err_led        (err_led),
    .screen_color   (screen_color)
  );

  esp_bridge u_esp_bridge (
    .clk            (clk),
    .cass_out_sel_n (cass_out_sel_n),
    .ioreq_n        (ioreq_n),
    .in_n           (in_n),
    .out_n          (out_n),
    .done           (done),
    .data_ready_set (data_ready_set),
    .a              (a),
    .req            (req),
    .wait_n         (wait_n),
    .int_req        (int_req),
    .esp_s          (esp_s)
  );

endmodule

// ==== verification/tb_checks.sv ====
module tb_checks (
  input  logic        clk,
  input  logic        cass_out_sel_n,
  input  logic        miso,
  input  logic        done,
  input  logic        req,
  input  logic        wait_n,
  input  logic [3:0]  esp_s,
  input  logic        int_req,
  input  logic        led_red,
  input  logic        led_green,
  input  logic        led_blue,
  input  logic        err_led,
  input  logic [23:0] screen_color,
  input  logic        settled,      // no frame or bus access in flight
  input  logic        bus_miss,     // access to a port nobody decodes
  input  logic [2:0]  exp_led,      // {blue, green, red}
  input  logic [23:0] exp_color,
  input  logic        exp_err,
  input  logic        exp_int,
  input  logic [3:0]  exp_esp,
  output logic        check_failed
);

  timeunit 1ns;
  timeprecision 100ps;

  initial check_failed = 1'b0;

  // register state once the last command has landed
  led_state: assert property (@(posedge clk) disable iff (!cass_out_sel_n)
    settled |-> ({led_blue, led_green, led_red} == exp_led))
    else begin
      $display("Fail led_state expected %h actual %h", exp_led, {led_blue, led_green, led_red});
      check_failed = 1'b1;
    end

  color_state: assert property (@(posedge clk) disable iff (!cass_out_sel_n)
    settled |-> (screen_color == exp_color))
    else begin
      $display("Fail color_state expected %h actual %h", exp_color, screen_color);
      check_failed = 1'b1;
    end

  err_state: assert property (@(posedge clk) disable iff (!cass_out_sel_n)
    settled |-> (err_led == exp_err))
    else begin
      $display("Fail err_state expected %h actual %h", exp_err, err_led);
      check_failed = 1'b1;
    end

  irq_state: assert property (@(posedge clk) disable iff (!cass_out_sel_n)
    settled |-> (int_req == exp_int))
    else begin
      $display("Fail irq_state expected %h actual %h", exp_int, int_req);
      check_failed = 1'b1;
    end

  // quiet bus and link
  idle_outputs: assert property (@(posedge clk) disable iff (!cass_out_sel_n)
    settled |-> (!req && wait_n && !miso))
    else begin
      $display("idle_outputs: req, wait_n or miso active while nothing is in flight");
      check_failed = 1'b1;
    end

  // pulse is 50 cycles, no more and no less
  req_length: assert property (@(posedge clk) disable iff (!cass_out_sel_n)
    $fell(req) |-> ($past(req, 50) && !$past(req, 51)))
    else begin
      $display("req_length: request pulse was not 50 cycles long");
      check_failed = 1'b1;
    end

  wait_start: assert property (@(posedge clk) disable iff (!cass_out_sel_n)
    $rose(req) == $fell(wait_n))
    else begin
      $display("wait_start: wait_n did not fall in the cycle req rose");
      check_failed = 1'b1;
    end

  // done edge plus sync plus edge detect
  wait_end: assert property (@(posedge clk) disable iff (!cass_out_sel_n)
    $rose(wait_n) |-> ($past(done, 3) && !$past(done, 4)))
    else begin
      $display("wait_end: wait_n did not rise 3 cycles after done rose");
      check_failed = 1'b1;
    end

  status_code: assert property (@(posedge clk) disable iff (!cass_out_sel_n)
    req |-> (esp_s == exp_esp))
    else begin
      $display("Fail status_code expected %h actual %h", exp_esp, esp_s);
      check_failed = 1'b1;
    end

  port_miss: assert property (@(posedge clk) disable iff (!cass_out_sel_n)
    bus_miss |-> (!req && wait_n))
    else begin
      $display("port_miss: an undecoded port raised req or dropped wait_n");
      check_failed = 1'b1;
    end

  // no selection, so the idle code stays up
  miss_status: assert property (@(posedge clk) disable iff (!cass_out_sel_n)
    bus_miss |-> (esp_s == exp_esp))
    else begin
      $display("Fail miss_status expected %h actual %h", exp_esp, esp_s);
      check_failed = 1'b1;
    end

endmodule

// ==== verification/tb_top.sv ====
module tb_top
  import spi_cmd_pkg::*;
();

  timeunit 1ns;
  timeprecision 100ps;

  localparam int          spi_half       = 8;      // clk cycles per sck half period
  localparam int          reset_cycles   = 4;
  localparam int          miss_hold      = 12;     // long enough for a req to show up
  localparam int          timeout_cycles = 20000;
  localparam logic [7:0]  exp_cookie     = 8'haf;
  localparam logic [7:0]  exp_version    = 8'h03;  // major 0, minor 3
  localparam logic [7:0]  bad_opcode     = 8'h63;
  localparam logic [3:0]  code_trs_in    = 4'h0;
  localparam logic [3:0]  code_frehd_out = 4'h3;
  localparam logic [3:0]  code_idle      = 4'hf;

  logic        clk;
  logic        cass_out_sel_n;
  logic        sck;
  logic        cs_n;
  logic        mosi;
  logic        miso;
  logic        ioreq_n;
  logic        in_n;
  logic        out_n;
  logic [7:0]  a;
  logic        done;
  logic        req;
  logic [3:0]  esp_s;
  logic        wait_n;
  logic        int_req;
  logic        led_red;
  logic        led_green;
  logic        led_blue;
  logic        err_led;
  logic [23:0] screen_color;

  // expected state, fed to the checker
  logic        settled;
  logic        bus_miss;
  logic [2:0]  exp_led;
  logic [23:0] exp_color;
  logic        exp_err;
  logic        exp_int;
  logic [3:0]  exp_esp;
  logic        check_failed;

  integer      seed;
  int          cycles;

  trs_io_top u_dut (
    .clk            (clk),
    .cass_out_sel_n (cass_out_sel_n),
    .sck            (sck),
    .cs_n           (cs_n),
    .mosi           (mosi),
    .miso           (miso),
    .ioreq_n        (ioreq_n),
    .in_n           (in_n),
    .out_n          (out_n),
    .a              (a),
    .done           (done),
    .req            (req),
    .esp_s          (esp_s),
    .wait_n         (wait_n),
    .int_req        (int_req),
    .led_red        (led_red),
    .led_green      (led_green),
    .led_blue       (led_blue),
    .err_led        (err_led),
    .screen_color   (screen_color)
  );

  tb_checks u_checks (
    .clk            (clk),
    .cass_out_sel_n (cass_out_sel_n),
    .miso           (miso),
    .done           (done),
    .req            (req),
    .wait_n         (wait_n),
    .esp_s          (esp_s),
    .int_req        (int_req),
    .led_red        (led_red),
    .led_green      (led_green),
    .led_blue       (led_blue),
    .err_led        (err_led),
    .screen_color   (screen_color),
    .settled        (settled),
    .bus_miss       (bus_miss),
    .exp_led        (exp_led),
    .exp_color      (exp_color),
    .exp_err        (exp_err),
    .exp_int        (exp_int),
    .exp_esp        (exp_esp),
    .check_failed   (check_failed)
  );

  initial begin
    clk = 1'b0;
    forever #10 clk = ~clk; // 20 ns period
  end

  task automatic abort_run(input string why);
    $display("%s", why);
    $display("test failed");
    $fatal(1, "simulation stopped");
  endtask

  always @(posedge clk) begin
    cycles <= cycles + 1;
    if (cycles == timeout_cycles)
      abort_run("run hung, the test sequence did not finish within the cycle limit");
  end

  always @(posedge clk) begin
    if (check_failed)
      abort_run("a port check in tb_checks did not hold");
  end

  // one byte, msb first, mode 0
  task automatic spi_byte(input logic [7:0] tx, output logic [7:0] rx);
    int i;
    rx = 8'h00;
    for (i = 7; i >= 0; i--) begin
      mosi <= tx[i];
      repeat (spi_half) @(posedge clk);
      rx = {rx[6:0], miso};   // settled since the last falling sck
      sck <= 1'b1;
      repeat (spi_half) @(posedge clk);
      sck <= 1'b0;
    end
  endtask

  task automatic frame_start;
    settled <= 1'b0;
    cs_n    <= 1'b0;
    repeat (spi_half) @(posedge clk);
  endtask

  task automatic frame_end;
    repeat (spi_half) @(posedge clk);
    cs_n <= 1'b1;
    repeat (spi_half) @(posedge clk); // let cs_n pass the synchronizer
    settled <= 1'b1;
    @(posedge clk);                   // state checks sample here
  endtask

  // reply command followed by a dummy byte that clocks the answer out
  task automatic check_reply(input string name, input logic [7:0] op, input logic [7:0] exp);
    logic [7:0] rx;
    frame_start();
    spi_byte(op, rx);
    spi_byte(8'h00, rx);
    frame_end();
    if (rx !== exp)
      abort_run($sformatf("Fail %s expected %h actual %h", name, exp, rx));
  endtask

  task automatic send_write(input logic [7:0] op, input int nparams, input logic [7:0] p0,
                            input logic [7:0] p1, input logic [7:0] p2);
    logic [7:0] rx;
    frame_start();
    spi_byte(op, rx);
    if (nparams > 0)
      spi_byte(p0, rx);
    if (nparams > 1)
      spi_byte(p1, rx);
    if (nparams > 2)
      spi_byte(p2, rx);
    frame_end();
  endtask

  // one z80 IN or OUT, host answers with done once req has dropped
  task automatic bus_access(input logic [7:0] port, input logic is_read, input logic hit,
                            input logic [3:0] code);
    settled  <= 1'b0;
    bus_miss <= !hit;
    exp_esp  <= code;
    a        <= port;
    ioreq_n  <= 1'b0;
    in_n     <= !is_read;
    out_n    <= is_read;
    if (hit) begin
      @(posedge clk);
      while (!req)
        @(posedge clk);
      while (req)
        @(posedge clk);
      done <= 1'b1;
      @(posedge clk);
      while (!wait_n)
        @(posedge clk);
      done <= 1'b0;
    end else begin
      repeat (miss_hold) @(posedge clk);
    end
    ioreq_n <= 1'b1;
    in_n    <= 1'b1;
    out_n   <= 1'b1;
    repeat (4) @(posedge clk);
    bus_miss <= 1'b0;
    settled  <= 1'b1;
    @(posedge clk);
  endtask

  task automatic apply_reset;
    settled        <= 1'b0;
    cass_out_sel_n <= 1'b0;
    exp_led        <= 3'b000;   // leds off
    exp_color      <= 24'hffffff;
    exp_err        <= 1'b0;
    exp_int        <= 1'b0;
    repeat (reset_cycles) @(posedge clk);
    cass_out_sel_n <= 1'b1;
    repeat (4) @(posedge clk);
    settled <= 1'b1;
    @(posedge clk);
  endtask

  initial begin : main
    logic [31:0] rnd;
    logic [7:0]  p0;
    logic [7:0]  p1;
    logic [7:0]  p2;
    logic [7:0]  port;
    seed           = 32'ha68bd211;
    cycles         = 0;
    cass_out_sel_n = 1'b0;
    sck            = 1'b0;
    cs_n           = 1'b1;
    mosi           = 1'b0;
    ioreq_n        = 1'b1;
    in_n           = 1'b1;
    out_n          = 1'b1;
    a              = 8'h00;
    done           = 1'b0;
    settled        = 1'b0;
    bus_miss       = 1'b0;
    exp_led        = 3'b000;
    exp_color      = 24'hffffff;
    exp_err        = 1'b0;
    exp_int        = 1'b0;
    exp_esp        = code_idle;
    @(posedge clk);
    apply_reset();

    check_reply("get_cookie", cmd_get_cookie, exp_cookie);
    check_reply("get_version", cmd_get_version, exp_version);

    // a moves with the bus idle, so no access is decoded
    rnd = $random(seed);
    a <= rnd[7:0];
    @(posedge clk);
    check_reply("abus_read", cmd_abus_read, rnd[7:0]);

    rnd = $random(seed);
    p0 = rnd[7:0];
    exp_led <= p0[2:0];        // bit 0 red, bit 2 blue
    send_write(cmd_set_led, 1, p0, 8'h00, 8'h00);

    rnd = $random(seed);
    p0 = rnd[7:0];
    p1 = rnd[15:8];
    p2 = rnd[23:16];
    exp_color <= {p0, p1, p2}; // first byte lands high
    send_write(cmd_set_screen_color, 3, p0, p1, p2);

    exp_int <= 1'b1;
    send_write(cmd_data_ready, 0, 8'h00, 8'h00, 8'h00);

    // frehd leaves the irq alone, trs-io clears it
    rnd = $random(seed);
    port = {4'hc, rnd[3:0]};
    bus_access(port, 1'b0, 1'b1, code_frehd_out);
    exp_int <= 1'b0;
    bus_access(8'h1f, 1'b1, 1'b1, code_trs_in);

    rnd  = $random(seed);
    port = rnd[7:0];
    while (port == 8'h1f || port[7:4] == 4'hc) begin
      rnd  = $random(seed);
      port = rnd[7:0];
    end
    bus_access(port, 1'b1, 1'b0, code_idle);

    exp_err <= 1'b1;
    send_write(bad_opcode, 0, 8'h00, 8'h00, 8'h00);
    check_reply("get_cookie_after_error", cmd_get_cookie, exp_cookie);

    apply_reset();               // only reset clears err_led
    repeat (8) @(posedge clk);
    settled <= 1'b0;
    @(posedge clk);              // last checker results are in

    if (check_failed) begin
      abort_run("a port check in tb_checks did not hold");
    end else begin
      $display("test passed");
      $finish;
    end
  end

endmodule

// ==== tb.f ====
common/spi_cmd_pkg.sv
common/trs_bus_pkg.sv
spi/spi_link.sv
rtl/cmd_ctrl.sv
rtl/host_regs.sv
rtl/esp_bridge.sv
rtl/trs_io_top.sv
verification/tb_checks.sv
verification/tb_top.sv

// ==== Makefile ====
# Verilator flow for the TRS-IO host board testbench

VERILATOR  ?= verilator
TOP        ?= tb_top
FILELIST   ?= tb.f
BUILD_DIR  ?= obj_dir
LOG        ?= sim.log
TIMESCALE  ?= 1ns/100ps
COMMON     ?= --timing --assert --timescale $(TIMESCALE) -Wno-fatal
BUILD_OPTS ?= --binary -j 0
PASS_MSG   ?= test passed

.PHONY: all lint sim clean

all: sim

lint:
	$(VERILATOR) --lint-only $(COMMON) --top-module $(TOP) -f $(FILELIST)

sim:
	$(VERILATOR) $(BUILD_OPTS) $(COMMON) --top-module $(TOP) -f $(FILELIST) --Mdir $(BUILD_DIR)
	./$(BUILD_DIR)/V$(TOP) 2>&1 | tee $(LOG)
	grep -qx "$(PASS_MSG)" $(LOG)

clean:
	rm -rf $(BUILD_DIR) $(LOG)
